/* include/sparc_defines.svh */
`ifndef SPARC_DEFINES_SVH
`define SPARC_DEFINES_SVH

// Data path and field widths
`define WORD_W        32
`define REG_ADDR_W    5
`define OP3_W         6
`define CLASS_W       3

// Instruction classes out of decode
`define CLASS_SETHI   3'd0
`define CLASS_BRANCH  3'd1
`define CLASS_CALL    3'd2
`define CLASS_ARITH   3'd3
`define CLASS_ILLEGAL 3'd4

// op2 values for format 2
`define OP2_SETHI     3'b100
`define OP2_BICC      3'b010

// op3 values, bit 4 selects the cc form
`define OP3_ADD       6'b000000
`define OP3_AND       6'b000001
`define OP3_OR        6'b000010
`define OP3_XOR       6'b000011
`define OP3_SUB       6'b000100

`define CALL_LINK_REG 5'd15 // o7 gets the CALL address

// Bicc cond[2:0]; cond[3] set gives the negated test
`define COND_NEVER    3'd0
`define COND_EQ       3'd1
`define COND_LE       3'd2
`define COND_LT       3'd3
`define COND_LEU      3'd4
`define COND_CS       3'd5
`define COND_NEG      3'd6
`define COND_VS       3'd7

`endif

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module sparcCoreTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "^test passed$" &&
echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

/* src.f */
+incdir+include
verilog/sparcPkg.sv
verilog/instrSequencer.sv
verilog/instrDecode.sv
verilog/aluExecute.sv
verilog/resultStage.sv
verilog/sparcCore.sv
verification/sparcCoreTb.sv

/* verification/sparcCoreTb.sv */
`default_nettype none

`include "sparc_defines.svh"

module sparcCoreTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HeaderLen = 7;
	localparam int NumRandom = 300;
	localparam int ProgLen = HeaderLen + NumRandom;
	localparam int TimeoutNs = (ProgLen * 12 + 20) * 4; // 12 cycles per instruction at most

	logic Clk, RESET;
	logic memRead, memReady;
	logic [`WORD_W-1:0] memAddr, memData;
	logic [`REG_ADDR_W-1:0] regReadAddrA, regReadAddrB, regWriteAddr;
	logic [`WORD_W-1:0] regReadDataA, regReadDataB, regWriteData;
	logic regWriteEn, illegalInstr;

	logic [31:0] prog [0:511];
	logic [31:0] regs [0:31]; // Register file model
	logic [31:0] endAddr;
	integer seed = 19;
	int progCnt;

	sparcCore uut (
		.Clk(Clk), .RESET(RESET),
		.memRead(memRead), .memAddr(memAddr), .memData(memData), .memReady(memReady),
		.regReadAddrA(regReadAddrA), .regReadAddrB(regReadAddrB),
		.regReadDataA(regReadDataA), .regReadDataB(regReadDataB),
		.regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .illegalInstr(illegalInstr)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkAddr(input string name, input logic [`WORD_W-1:0] exp,
		input logic [`WORD_W-1:0] act);
		if (exp !== act)
			failRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkData(input string name, input logic [`WORD_W-1:0] exp,
		input logic [`WORD_W-1:0] act);
		if (exp !== act)
			failRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkIndex(input string name, input logic [`REG_ADDR_W-1:0] exp,
		input logic [`REG_ADDR_W-1:0] act);
		if (exp !== act)
			failRun($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act)
			failRun($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	function automatic logic [31:0] randWord();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[progCnt] = w;
		progCnt = progCnt + 1;
	endtask

	// Random instruction of one of the supported or illegal kinds
	function automatic logic [31:0] randInstr();
		logic [31:0] r, s;
		logic [5:0] op3;
		r = randWord();
		s = randWord();
		case (r[2:0])
			3'd3:
				return {2'b00, r[7:3], `OP2_SETHI, s[21:0]}; // SETHI
			3'd4:
				return {2'b00, r[3], s[7:4], `OP2_BICC, 20'd0, s[1:0]} + 32'd1; // Short forward
			3'd5:
				return {2'b01, 28'd0, s[1:0]} + 32'd1; // CALL 1 to 4 words ahead
			3'd6:
			begin
				case (r[4:3])
					2'd0: return {2'b11, s[29:0]}; // Load or store
					2'd1: return {2'b00, s[4:0], 3'b000, s[26:5]}; // UNIMP op2
					2'd2: return {2'b10, s[4:0], 6'b111000, s[23:5]}; // JMPL
					default: return {2'b10, s[4:0], 6'b001000, s[23:5]}; // ADDX
				endcase
			end
			default:
			begin
				case (s[2:0])
					3'd0, 3'd5: op3 = `OP3_ADD;
					3'd1, 3'd6: op3 = `OP3_AND;
					3'd2, 3'd7: op3 = `OP3_OR;
					3'd3: op3 = `OP3_XOR;
					default: op3 = `OP3_SUB;
				endcase
				op3[4] = s[3]; // cc form
				return {2'b10, r[7:3], op3, r[12:8], s[4], r[25:13]};
			end
		endcase
	endfunction

	// SPARC Bicc table on N Z V C
	function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] icc);
		logic n, z, v, c;
		{n, z, v, c} = icc;
		case (cond)
			4'h0: return 1'b0;
			4'h1: return z;
			4'h2: return z | (n ^ v);
			4'h3: return n ^ v;
			4'h4: return c | z;
			4'h5: return c;
			4'h6: return n;
			4'h7: return v;
			4'h8: return 1'b1;
			4'h9: return ~z;
			4'hA: return ~(z | (n ^ v));
			4'hB: return ~(n ^ v);
			4'hC: return ~(c | z);
			4'hD: return ~c;
			4'hE: return ~n;
			default: return ~v;
		endcase
	endfunction

	// Expected effect of one instruction on the model state
	function automatic void predict(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] pcIn, input logic [31:0] npcIn, input logic [3:0] iccIn,
		output logic we, output logic [4:0] wa, output logic [31:0] wd, output logic ill,
		output logic [3:0] iccOut, output logic [31:0] pcOut, output logic [31:0] npcOut);
		logic [31:0] opB;
		logic [32:0] wide;
		logic [32:0] ext; // Signed result, one guard bit
		logic [5:0] base;
		logic v, c;
		we = 1'b0;
		ill = 1'b0;
		wa = w[29:25];
		wd = '0;
		iccOut = iccIn;
		pcOut = npcIn;
		npcOut = npcIn + 32'd4;
		v = 1'b0;
		c = 1'b0;
		base = {w[24], 1'b0, w[22:19]};
		opB = w[13] ? {{19{w[12]}}, w[12:0]} : b;
		case (w[31:30])
			2'b01:
			begin
				we = 1'b1;
				wa = 5'd15;
				wd = pcIn;
				npcOut = pcIn + {w[29:0], 2'b00};
			end
			2'b00:
			begin
				if (w[24:22] == 3'b100)
				begin
					we = 1'b1;
					wd = {w[21:0], 10'b0};
				end
				else if (w[24:22] == 3'b010)
				begin
					if (condHolds(w[28:25], iccIn))
						npcOut = pcIn + {{8{w[21]}}, w[21:0], 2'b00};
				end
				else
					ill = 1'b1;
			end
			2'b10:
			begin
				we = 1'b1;
				case (base)
					6'd0:
					begin
						wide = {1'b0, a} + {1'b0, opB};
						ext = {a[31], a} + {opB[31], opB};
						wd = wide[31:0];
						c = wide[32];
						v = ext[32] ^ ext[31]; // Out of signed 32-bit range
					end
					6'd4:
					begin
						wide = {1'b0, a} - {1'b0, opB};
						ext = {a[31], a} - {opB[31], opB};
						wd = wide[31:0];
						c = wide[32]; // Borrow
						v = ext[32] ^ ext[31];
					end
					6'd1: wd = a & opB;
					6'd2: wd = a | opB;
					6'd3: wd = a ^ opB;
					default:
					begin
						we = 1'b0;
						ill = 1'b1;
					end
				endcase
				if (!ill && w[23])
					iccOut = {wd[31], wd == 32'd0, v, c};
			end
			default:
				ill = 1'b1; // Memory format
		endcase
	endfunction

	// Program and register contents
	initial
	begin
		progCnt = 0;
		for (int i = 0; i < 512; i++)
			prog[i] = {i[15:0], ~i[15:0]}; // Fill, never fetched
		for (int i = 0; i < 32; i++)
			regs[i] = randWord();
		regs[0] = '0;
		emit(32'h0304_8D15); // sethi r1
		emit({2'b10, 5'd2, `OP3_OR, 5'd1, 1'b1, 13'h3FF}); // or r2, r1, 0x3ff
		emit({2'b10, 5'd0, 6'b010100, 5'd2, 1'b0, 8'd0, 5'd2}); // subcc r2, r2 sets Z
		emit({2'b00, 1'b0, 4'h1, `OP2_BICC, 22'd2}); // be, taken
		emit({2'b10, 5'd3, `OP3_ADD, 5'd0, 1'b1, 13'd5}); // Delay slot
		emit({2'b01, 30'd2}); // call past the next word
		emit({2'b10, 5'd4, `OP3_XOR, 5'd1, 1'b0, 8'd0, 5'd2}); // Delay slot
		for (int i = 0; i < NumRandom; i++)
			emit(randInstr());
		endAddr = ProgLen * 4;
	end

	assign regReadDataA = regs[regReadAddrA];
	assign regReadDataB = regs[regReadAddrB];

	// Register file writes, r0 stays zero
	always @(posedge Clk)
	begin
		logic [4:0] wa;
		logic [31:0] wd;
		logic we;
		we = regWriteEn;
		wa = regWriteAddr;
		wd = regWriteData;
		#1;
		if (we && wa != 5'd0)
			regs[wa] = wd;
	end

	// Memory answers after 0 to 3 wait cycles
	initial
	begin
		int waitCnt;
		logic [31:0] r;
		memReady = 1'b0;
		memData = '0;
		waitCnt = -1;
		forever
		begin
			@(posedge Clk);
			#1;
			memReady = 1'b0;
			if (memRead)
			begin
				if (waitCnt < 0)
				begin
					r = randWord();
					waitCnt = {30'd0, r[1:0]};
				end
				if (waitCnt == 0)
				begin
					memReady = 1'b1;
					memData = prog[memAddr[10:2]];
				end
				waitCnt = waitCnt - 1;
			end
		end
	end

	initial
	begin
		RESET = 1'b1;
		repeat (5)
		begin
			@(posedge Clk);
			#1;
			checkFlag("memRead in reset", 1'b0, memRead);
			checkFlag("regWriteEn in reset", 1'b0, regWriteEn);
			checkFlag("illegalInstr in reset", 1'b0, illegalInstr);
		end
		RESET = 1'b0;
	end

	// Compare process, one instruction per pass
	initial
	begin
		logic [31:0] pcM, npcM, w, wd, pcN, npcN;
		logic [3:0] iccM, iccN;
		logic [4:0] wa;
		logic we, ill;
		int writes, ills, cyc;
		pcM = '0;
		npcM = 32'd4;
		iccM = '0;
		@(negedge Clk);
		while (RESET)
			@(negedge Clk);
		// Next edge sees RESET low and starts the first fetch
		@(negedge Clk);
		checkFlag("memRead in first cycle after reset", 1'b1, memRead);
		checkAddr("fetch address", pcM, memAddr);
		while (pcM < endAddr)
		begin
			w = prog[pcM[10:2]];
			predict(w, regs[w[18:14]], regs[w[4:0]], pcM, npcM, iccM,
				we, wa, wd, ill, iccN, pcN, npcN);
			while (memRead)
			begin
				checkAddr("fetch address held", pcM, memAddr);
				@(negedge Clk);
			end
			writes = 0;
			ills = 0;
			cyc = 0;
			while (!memRead)
			begin
				if (regWriteEn)
				begin
					writes++;
					checkFlag("write in writeback cycle", 1'b1, cyc == 2);
					checkIndex("write address", wa, regWriteAddr);
					checkData("write data", wd, regWriteData);
					if (w[31:30] == 2'b10)
					begin
						checkIndex("read address A", w[18:14], regReadAddrA);
						if (!w[13])
							checkIndex("read address B", w[4:0], regReadAddrB);
					end
					else if (w[31:30] == 2'b00)
						checkIndex("SETHI read address A", 5'd0, regReadAddrA);
				end
				if (illegalInstr)
				begin
					ills++;
					checkFlag("illegal in writeback cycle", 1'b1, cyc == 2);
				end
				cyc++;
				@(negedge Clk);
			end
			checkFlag("four cycles between fetches", 1'b1, cyc == 4);
			checkFlag("register write pulse", we, writes == 1);
			checkFlag("illegal pulse", ill, ills == 1);
			pcM = pcN;
			npcM = npcN;
			iccM = iccN;
			checkAddr("fetch address", pcM, memAddr);
		end
		$display("test passed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TimeoutNs);
		$display("Timeout, the core stopped fetching before the program ended");
		$display("test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* verilog/aluExecute.sv */
`default_nettype none

`include "sparc_defines.svh"

module aluExecute
(
	input wire logic [`OP3_W-1:0] aluOp,
	input wire logic selectPcA,
	input wire logic useImmediate,
	input wire logic [`WORD_W-1:0] immediate,
	input wire logic [`WORD_W-1:0] regReadDataA,
	input wire logic [`WORD_W-1:0] regReadDataB,
	input wire logic [`WORD_W-1:0] pc,
	output logic [`WORD_W-1:0] aluResult,
	output logic [3:0] newFlags // N Z V C
);

	localparam int Msb = `WORD_W - 1;

	logic [`WORD_W-1:0] opA, opB;
	logic [`WORD_W:0] sum; // Carry in the top bit
	logic [`WORD_W:0] diff; // Borrow in the top bit
	logic overflowAdd, overflowSub;
	logic flagV, flagC;
	logic flagN, flagZ;

	// Operand muxes
	assign opA = selectPcA ? pc : regReadDataA;
	assign opB = useImmediate ? immediate : regReadDataB;

	assign sum = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};

	// Same signs in, other sign out
	assign overflowAdd = (opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb]);
	// Signs differ and result flips away from A
	assign overflowSub = (opA[Msb] != opB[Msb]) && (diff[Msb] != opA[Msb]);

	always_comb
	begin
		flagV = 1'b0; // Logic ops clear V and C
		flagC = 1'b0;
		case (aluOp)
			`OP3_ADD:
			begin
				aluResult = sum[Msb:0];
				flagV = overflowAdd;
				flagC = sum[`WORD_W];
			end
			`OP3_SUB:
			begin
				aluResult = diff[Msb:0];
				flagV = overflowSub;
				flagC = diff[`WORD_W]; // SPARC borrow
			end
			`OP3_AND:
				aluResult = opA & opB;
			`OP3_OR:
				aluResult = opA | opB;
			`OP3_XOR:
				aluResult = opA ^ opB;
			default:
				aluResult = '0; // Decode never sends anything else
		endcase
	end

	assign flagN = aluResult[Msb];
	assign flagZ = (aluResult == '0);
	assign newFlags = {flagN, flagZ, flagV, flagC};

endmodule

`default_nettype wire

/* verilog/instrDecode.sv */
`default_nettype none

`include "sparc_defines.svh"

module instrDecode import sparcPkg::*;
(
	input instrWord_t ir,
	output logic [`CLASS_W-1:0] instrClass,
	output logic [`OP3_W-1:0] aluOp,
	output logic setFlags,
	output logic selectPcA,
	output logic useImmediate,
	output logic [`WORD_W-1:0] immediate,
	output logic [`REG_ADDR_W-1:0] regReadAddrA,
	output logic [`REG_ADDR_W-1:0] regReadAddrB,
	output logic [`REG_ADDR_W-1:0] writeAddr
);

	logic [`OP3_W-1:0] baseOp3;
	logic arithKnown;
	logic isSethi, isCall, isArith;

	// op3 with the cc bit stripped
	assign baseOp3 = {ir.fmt3.op3[5], 1'b0, ir.fmt3.op3[3:0]};

	always_comb
	begin
		case (baseOp3)
			`OP3_ADD, `OP3_AND, `OP3_OR, `OP3_XOR, `OP3_SUB:
				arithKnown = 1'b1;
			default:
				arithKnown = 1'b0; // JMPL, SAVE, traps and the rest
		endcase
	end

	// Classify on op, then op2 or op3
	always_comb
	begin
		instrClass = `CLASS_ILLEGAL;
		case (ir.fmt1.op)
			2'b00:
			begin
				if (ir.fmt2.op2 == `OP2_SETHI)
					instrClass = `CLASS_SETHI;
				else if (ir.fmt2.op2 == `OP2_BICC)
					instrClass = `CLASS_BRANCH;
			end
			2'b01:
				instrClass = `CLASS_CALL;
			2'b10:
			begin
				if (arithKnown)
					instrClass = `CLASS_ARITH;
			end
			default:
				instrClass = `CLASS_ILLEGAL; // Loads and stores
		endcase
	end

	assign isSethi = (instrClass == `CLASS_SETHI);
	assign isCall = (instrClass == `CLASS_CALL);
	assign isArith = (instrClass == `CLASS_ARITH);

	// SETHI and CALL both go through the adder
	assign aluOp = isArith ? baseOp3 : `OP3_ADD;
	assign setFlags = isArith && ir.fmt3.op3[4];
	assign selectPcA = isCall; // Link value is PC itself
	assign useImmediate = isSethi || isCall || (isArith && ir.fmt3.i);

	always_comb
	begin
		case (instrClass)
			`CLASS_SETHI:
				immediate = {ir.fmt2.imm22, 10'b0};
			`CLASS_CALL:
				immediate = '0; // PC plus zero
			default:
				immediate = {{(`WORD_W - 13){ir.fmt3.low13[12]}}, ir.fmt3.low13};
		endcase
	end

	// Register ports
	assign regReadAddrA = (isSethi || isCall) ? '0 : ir.fmt3.rs1; // r0 for SETHI
	assign regReadAddrB = ir.fmt3.low13[`REG_ADDR_W-1:0];
	assign writeAddr = isCall ? `CALL_LINK_REG : ir.fmt3.rd;

endmodule

`default_nettype wire

/* verilog/instrSequencer.sv */
`default_nettype none

`include "sparc_defines.svh"

module instrSequencer import sparcPkg::*;
(
	input wire logic Clk,
	input wire logic RESET,
	// Fetch handshake
	output logic memRead,
	output logic [`WORD_W-1:0] memAddr,
	input wire logic [`WORD_W-1:0] memData,
	input wire logic memReady,
	// From decode and result
	input wire logic [`CLASS_W-1:0] instrClass,
	input wire logic [`WORD_W-1:0] nextNpc,
	input wire logic takeTarget,
	// Held state
	output instrWord_t ir,
	output logic [`WORD_W-1:0] pc,
	// Strobes
	output logic regWriteEn,
	output logic illegalInstr,
	output logic updateFlags,
	output logic advance
);

	// One state per cycle of the instruction
	localparam logic [2:0] stateInit = 3'd0;
	localparam logic [2:0] stateFetch = 3'd1; // Waits here for memReady
	localparam logic [2:0] stateDecode = 3'd2;
	localparam logic [2:0] stateExecute = 3'd3;
	localparam logic [2:0] stateWriteback = 3'd4;
	localparam logic [2:0] stateUpdate = 3'd5;

	logic [2:0] state;
	logic [`WORD_W-1:0] npc;
	logic irLoad;
	logic writesReg;

	// Next state
	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= stateInit;
		else
		begin
			case (state)
				stateInit:
					state <= stateFetch; // PC and NPC already set by reset
				stateFetch:
				begin
					if (memReady)
						state <= stateDecode; // Word lands in IR at this edge
				end
				stateDecode:
					state <= stateExecute;
				stateExecute:
					state <= stateWriteback;
				stateWriteback:
					state <= stateUpdate;
				stateUpdate:
					state <= stateFetch;
				default:
					state <= stateInit;
			endcase
		end
	end

	// Memory side
	assign memRead = (state == stateFetch);
	assign memAddr = pc; // Steady for the whole wait
	assign irLoad = memRead && memReady;

	always_ff @(posedge Clk)
	begin
		if (irLoad)
			ir <= memData;
	end

	// SETHI, CALL and arith all end in a register write
	assign writesReg = (instrClass == `CLASS_SETHI) || (instrClass == `CLASS_CALL)
		|| (instrClass == `CLASS_ARITH);

	assign updateFlags = (state == stateWriteback);
	assign regWriteEn = updateFlags && writesReg; // Branch writes nothing
	assign illegalInstr = updateFlags && (instrClass == `CLASS_ILLEGAL); // Flag then skip
	assign advance = (state == stateUpdate);

	// PC and NPC flow
	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			pc <= '0;
			npc <= `WORD_W'd4;
		end
		else if (advance)
		begin
			pc <= npc; // Delay slot or next in line
			if (takeTarget)
				npc <= nextNpc; // Taken branch or CALL
			else
				npc <= npc + `WORD_W'd4;
		end
	end

endmodule

`default_nettype wire

/* verilog/resultStage.sv */
`default_nettype none

`include "sparc_defines.svh"

module resultStage import sparcPkg::*;
(
	input wire logic Clk,
	input wire logic RESET,
	input instrWord_t ir,
	input wire logic [`WORD_W-1:0] pc,
	input wire logic [`CLASS_W-1:0] instrClass,
	input wire logic setFlags,
	input wire logic updateFlags,
	input wire logic [3:0] newFlags, // N Z V C
	output logic [`WORD_W-1:0] nextNpc,
	output logic takeTarget
);

	logic [3:0] icc;
	logic iccN, iccZ, iccV, iccC;
	logic condBase;
	logic condTrue;
	logic isCall;
	logic [`WORD_W-1:0] branchOffset;
	logic [`WORD_W-1:0] callOffset;

	// Integer condition codes of the PSR
	always_ff @(posedge Clk)
	begin
		if (RESET)
			icc <= 4'b0000;
		else if (updateFlags && setFlags)
			icc <= newFlags; // Only cc forms land here
	end

	assign {iccN, iccZ, iccV, iccC} = icc;

	// Lower half of the table, cond[3] inverts it
	always_comb
	begin
		case (ir.fmt2.cond[2:0])
			`COND_NEVER:
				condBase = 1'b0; // BN, or BA when inverted
			`COND_EQ:
				condBase = iccZ;
			`COND_LE:
				condBase = iccZ | (iccN ^ iccV);
			`COND_LT:
				condBase = iccN ^ iccV;
			`COND_LEU:
				condBase = iccC | iccZ;
			`COND_CS:
				condBase = iccC;
			`COND_NEG:
				condBase = iccN;
			default:
				condBase = iccV; // BVS
		endcase
	end

	assign condTrue = condBase ^ ir.fmt2.cond[3];

	// Word displacements scaled to bytes
	assign branchOffset = {{(`WORD_W - 24){ir.fmt2.imm22[21]}}, ir.fmt2.imm22, 2'b00};
	assign callOffset = {ir.fmt1.disp30, 2'b00};

	assign isCall = (instrClass == `CLASS_CALL);
	assign takeTarget = isCall || ((instrClass == `CLASS_BRANCH) && condTrue);

	// Target only; NPC plus 4 is formed in the sequencer
	assign nextNpc = pc + (isCall ? callOffset : branchOffset);

endmodule

`default_nettype wire

/* verilog/sparcCore.sv */
`default_nettype none

`include "sparc_defines.svh"

module sparcCore import sparcPkg::*;
(
	input wire logic Clk,
	input wire logic RESET,
	// Instruction memory
	output logic memRead,
	output logic [`WORD_W-1:0] memAddr,
	input wire logic [`WORD_W-1:0] memData,
	input wire logic memReady,
	// External register file
	output logic [`REG_ADDR_W-1:0] regReadAddrA,
	output logic [`REG_ADDR_W-1:0] regReadAddrB,
	input wire logic [`WORD_W-1:0] regReadDataA,
	input wire logic [`WORD_W-1:0] regReadDataB,
	output logic regWriteEn,
	output logic [`REG_ADDR_W-1:0] regWriteAddr,
	output logic [`WORD_W-1:0] regWriteData,
	output logic illegalInstr
);

	instrWord_t ir;
	logic [`WORD_W-1:0] pc;
	logic [`CLASS_W-1:0] instrClass;
	logic [`OP3_W-1:0] aluOp;
	logic setFlags, selectPcA, useImmediate;
	logic [`WORD_W-1:0] immediate;
	logic [3:0] newFlags; // N Z V C
	logic [`WORD_W-1:0] nextNpc;
	logic takeTarget;
	logic updateFlags;

	instrSequencer sequencer (
		.Clk(Clk), .RESET(RESET),
		.memRead(memRead), .memAddr(memAddr), .memData(memData), .memReady(memReady),
		.instrClass(instrClass), .nextNpc(nextNpc), .takeTarget(takeTarget),
		.ir(ir), .pc(pc),
		.regWriteEn(regWriteEn), .illegalInstr(illegalInstr),
		.updateFlags(updateFlags), .advance()
	);

	instrDecode decode (
		.ir(ir), .instrClass(instrClass), .aluOp(aluOp), .setFlags(setFlags),
		.selectPcA(selectPcA), .useImmediate(useImmediate), .immediate(immediate),
		.regReadAddrA(regReadAddrA), .regReadAddrB(regReadAddrB),
		.writeAddr(regWriteAddr) // Straight out to the file
	);

	aluExecute execute (
		.aluOp(aluOp), .selectPcA(selectPcA), .useImmediate(useImmediate),
		.immediate(immediate), .regReadDataA(regReadDataA), .regReadDataB(regReadDataB),
		.pc(pc), .aluResult(regWriteData), .newFlags(newFlags)
	);

	resultStage result (
		.Clk(Clk), .RESET(RESET), .ir(ir), .pc(pc), .instrClass(instrClass),
		.setFlags(setFlags), .updateFlags(updateFlags), .newFlags(newFlags),
		.nextNpc(nextNpc), .takeTarget(takeTarget)
	);

endmodule

`default_nettype wire

/* verilog/sparcPkg.sv */
`default_nettype none

`include "sparc_defines.svh"

package sparcPkg;

	// Format 1, CALL only
	typedef struct packed {
		logic [1:0] op;
		logic [29:0] disp30; // Word displacement
	} fmt1_t;

	// Format 2, SETHI and Bicc
	// SETHI rd sits on annul and cond, read it through fmt3
	typedef struct packed {
		logic [1:0] op;
		logic annul; // Not honoured by this core
		logic [3:0] cond;
		logic [2:0] op2;
		logic [21:0] imm22; // disp22 for branches
	} fmt2_t;

	// Format 3, arith and logic
	typedef struct packed {
		logic [1:0] op;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`OP3_W-1:0] op3;
		logic [`REG_ADDR_W-1:0] rs1;
		logic i; // Immediate select
		logic [12:0] low13; // rs2 in [4:0] or simm13
	} fmt3_t;

	// One fetched word, three ways to look at it
	typedef union packed {
		fmt1_t fmt1;
		fmt2_t fmt2;
		fmt3_t fmt3;
	} instrWord_t;

endpackage

`default_nettype wire
